// File: verilog.f
+incdir+.
board_pkg.sv
board_reset.sv
bank_arbiter.sv
rom_memory.sv
board_top.sv
tb_clock.sv
board_tb.sv

// File: Makefile
# Verilator build for the memory-access core and its testbench

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= board_tb
LINT_TOP  ?= board_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out=$$($(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

// File: board_tb.sv
// Memory-access core testbench
// Checks the reset sequence, ROM download through the programming port,
// bank read-back, byte masks and four-bank contention against a
// reference memory model. Accesses come from a table applied in order.
`timescale 1ns/10ps
`default_nettype none

`include "board_cfg.svh"

module board_tb;

    import board_pkg::*;

    localparam int N_ROWS = 19;
    localparam int LIMIT  = N_ROWS * (`BOARD_MEM_LAT + 8) + `BOARD_RST_CYCLES + 100;

    // Ports 0 to 3 are game banks and port 4 is the programming port
    typedef struct packed {
        logic [2:0] port;
        logic       wr;
        bank_t      ba;
        addr_t      addr;
        data_t      data;
        dsn_t       dsn;
        data_t      exp_data;
        logic       group;
    } row_t;

    logic      clk_rom;
    logic      rst_n, pll_locked, rst_req, downloading;
    addr_t     ba0_addr, ba1_addr, ba2_addr, ba3_addr;
    data_t     ba0_din, ba1_din, ba2_din, ba3_din;
    dsn_t      ba0_dsn, ba1_dsn, ba2_dsn, ba3_dsn;
    bank_vec_t ba_rd, ba_wr, ba_ack, ba_rdy;
    logic      prog_rd, prog_we, prog_ack, prog_rdy;
    bank_t     prog_ba;
    addr_t     prog_addr;
    data_t     prog_data;
    dsn_t      prog_dsn;
    data_t     sdram_dout;
    logic      sdram_init, game_rst_n;

    row_t      tbl [N_ROWS];
    string     row_name [N_ROWS];
    int        n_rows;
    data_t     ref_mem [int];
    int        tick_no;
    int        wd_cycles;

    tb_clock u_clock (.clk(clk_rom));

    board_top dut0 (
        .clk_rom(clk_rom), .rst_n(rst_n), .pll_locked(pll_locked), .rst_req(rst_req),
        .downloading(downloading),
        .ba0_addr(ba0_addr), .ba1_addr(ba1_addr), .ba2_addr(ba2_addr), .ba3_addr(ba3_addr),
        .ba0_din(ba0_din), .ba1_din(ba1_din), .ba2_din(ba2_din), .ba3_din(ba3_din),
        .ba0_dsn(ba0_dsn), .ba1_dsn(ba1_dsn), .ba2_dsn(ba2_dsn), .ba3_dsn(ba3_dsn),
        .ba_rd(ba_rd), .ba_wr(ba_wr),
        .prog_rd(prog_rd), .prog_we(prog_we), .prog_ba(prog_ba), .prog_addr(prog_addr),
        .prog_data(prog_data), .prog_dsn(prog_dsn),
        .ba_ack(ba_ack), .ba_rdy(ba_rdy), .prog_ack(prog_ack), .prog_rdy(prog_rdy),
        .sdram_dout(sdram_dout), .sdram_init(sdram_init), .game_rst_n(game_rst_n)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else fail_now($sformatf("Mismatch %s: expected %0h, actual %0h", name, exp, act));
    endtask

    // Sample and drive point 5 ns after the rising edge
    task automatic tick();
        @(posedge clk_rom);
        #5;
        tick_no++;
    endtask

    // A low mask bit lets that byte of the new data in
    function automatic data_t merge_bytes(input data_t old, input data_t din, input dsn_t dsn);
        data_t res;
        res = old;
        if (!dsn[0]) res[7:0] = din[7:0];
        if (!dsn[1]) res[15:8] = din[15:8];
        return res;
    endfunction

    task automatic add_row(input string name, input int port, input logic wr, input int ba,
                           input addr_t addr, input data_t data, input dsn_t dsn,
                           input logic group);
        row_t r;
        int   key;
        key = ba * (1 << `BOARD_AW) + int'(addr);
        r.port = 3'(port);
        r.wr = wr;
        r.ba = bank_t'(ba);
        r.addr = addr;
        r.data = data;
        r.dsn = dsn;
        r.group = group;
        if (wr) ref_mem[key] = merge_bytes(ref_mem.exists(key) ? ref_mem[key] : '0, data, dsn);
        r.exp_data = ref_mem.exists(key) ? ref_mem[key] : '0;
        tbl[n_rows] = r;
        row_name[n_rows] = name;
        n_rows++;
    endtask

    task automatic build_table();
        addr_t a [4];
        for (int b = 0; b < 4; b++) begin
            a[b] = addr_t'($urandom);
            add_row($sformatf("prog write bank %0d", b), 4, 1'b1, b, a[b],
                    data_t'($urandom), 2'b00, 1'b0);
        end
        add_row("prog read bank 2", 4, 1'b0, 2, a[2], '0, 2'b00, 1'b0);
        add_row("held read bank 3", 3, 1'b0, 3, a[3], '0, 2'b00, 1'b0);
        for (int b = 0; b < 3; b++)
            add_row($sformatf("read back bank %0d", b), b, 1'b0, b, a[b], '0, 2'b00, 1'b0);
        add_row("write high byte", 1, 1'b1, 1, a[1], data_t'($urandom), 2'b01, 1'b0);
        add_row("read high merge", 1, 1'b0, 1, a[1], '0, 2'b00, 1'b0);
        add_row("write low byte", 1, 1'b1, 1, a[1], data_t'($urandom), 2'b10, 1'b0);
        add_row("read low merge", 1, 1'b0, 1, a[1], '0, 2'b00, 1'b0);
        add_row("write full word", 2, 1'b1, 2, a[2] ^ addr_t'(1), data_t'($urandom),
                2'b00, 1'b0);
        add_row("read full word", 2, 1'b0, 2, a[2] ^ addr_t'(1), '0, 2'b00, 1'b0);
        for (int b = 0; b < 4; b++)
            add_row($sformatf("contention bank %0d", b), b, 1'b0, b,
                    (b == 2) ? (a[2] ^ addr_t'(1)) : a[b], '0, 2'b00, 1'b1);
    endtask

    task automatic drive_port(input row_t r, input logic on);
        case (r.port)
            3'd0: begin
                ba0_addr = r.addr;
                ba0_din = r.data;
                ba0_dsn = r.dsn;
            end
            3'd1: begin
                ba1_addr = r.addr;
                ba1_din = r.data;
                ba1_dsn = r.dsn;
            end
            3'd2: begin
                ba2_addr = r.addr;
                ba2_din = r.data;
                ba2_dsn = r.dsn;
            end
            3'd3: begin
                ba3_addr = r.addr;
                ba3_din = r.data;
                ba3_dsn = r.dsn;
            end
            default: begin
                prog_ba = r.ba;
                prog_addr = r.addr;
                prog_data = r.data;
                prog_dsn = r.dsn;
            end
        endcase
        if (r.port == 3'd4) begin
            prog_rd = on && !r.wr;
            prog_we = on && r.wr;
        end else begin
            ba_rd[r.port[1:0]] = on && !r.wr;
            ba_wr[r.port[1:0]] = on && r.wr;
        end
    endtask

    function automatic logic port_ack(input int p);
        return (p == 4) ? prog_ack : ba_ack[p[1:0]];
    endfunction

    function automatic logic port_rdy(input int p);
        return (p == 4) ? prog_rdy : ba_rdy[p[1:0]];
    endfunction

    function automatic int find_row(input int first, input int last, input int p);
        for (int i = first; i <= last; i++)
            if (int'(tbl[i].port) == p) return i - first;
        return -1;
    endfunction

    task automatic start_rows(input int first, input int last);
        for (int i = first; i <= last; i++) drive_port(tbl[i], 1'b1);
    endtask

    // Waits for one ack and one rdy per row and drops each level after its rdy
    task automatic finish_rows(input int first, input int last);
        int ack_at [8];
        bit acked [8];
        bit drop [8];
        bit gone [8];
        int left;
        int k;
        left = last - first + 1;
        for (int i = 0; i < 8; i++) begin
            acked[i] = 1'b0;
            drop[i] = 1'b0;
            gone[i] = 1'b0;
        end
        while (left > 0) begin
            tick();
            for (int i = first; i <= last; i++) begin
                k = i - first;
                if (drop[k] && !gone[k]) begin
                    drive_port(tbl[i], 1'b0);
                    gone[k] = 1'b1;
                    left--;
                end
            end
            for (int p = 0; p <= 4; p++) begin
                k = find_row(first, last, p);
                if (port_ack(p)) begin
                    assert (k >= 0 && !acked[k])
                    else fail_now($sformatf("Unexpected ack on port %0d", p));
                    acked[k] = 1'b1;
                    ack_at[k] = tick_no;
                end
                if (port_rdy(p)) begin
                    assert (k >= 0 && acked[k] && !drop[k])
                    else fail_now($sformatf("Ready pulse without a pending ack on port %0d", p));
                    check_val({row_name[first + k], " latency"}, `BOARD_MEM_LAT,
                              tick_no - ack_at[k]);
                    if (!tbl[first + k].wr)
                        check_val(row_name[first + k], 32'(tbl[first + k].exp_data),
                                  32'(sdram_dout));
                    drop[k] = 1'b1;
                end
            end
        end
    endtask

    task automatic run_entries(input int first, input int last);
        int i;
        int j;
        i = first;
        while (i <= last) begin
            j = i;
            if (tbl[i].group)
                while (j + 1 <= last && tbl[j + 1].group) j++;
            start_rows(i, j);
            finish_rows(i, j);
            tick();
            i = j + 1;
        end
    endtask

    // Game reset must rise on exactly the last counted edge
    task automatic check_count(input string name);
        for (int k = 1; k <= `BOARD_RST_CYCLES; k++) begin
            tick();
            check_val({name, " game_rst_n"}, 32'(k == `BOARD_RST_CYCLES), 32'(game_rst_n));
            check_val({name, " sdram_init"}, 32'(k < `BOARD_INIT_CYCLES), 32'(sdram_init));
        end
    endtask

    always @(negedge clk_rom) begin
        wd_cycles++;
        assert (wd_cycles < LIMIT) else fail_now("Timeout, the run took too many cycles");
        assert ($countones({ba_ack, prog_ack}) <= 1)
        else fail_now("More than one ack in the same cycle");
        assert (!(downloading && game_rst_n))
        else fail_now("Game reset released while a download runs");
        if (!rst_n) begin
            assert (ba_ack == '0 && ba_rdy == '0 && !prog_ack && !prog_rdy)
            else fail_now("Ack or ready active during reset");
        end
    end

    initial begin
        rst_n = 1'b0;
        pll_locked = 1'b1;
        rst_req = 1'b0;
        downloading = 1'b0;
        {ba0_addr, ba1_addr, ba2_addr, ba3_addr} = '0;
        {ba0_din, ba1_din, ba2_din, ba3_din} = '0;
        {ba0_dsn, ba1_dsn, ba2_dsn, ba3_dsn} = '1;
        ba_rd = '0;
        ba_wr = '0;
        {prog_rd, prog_we, prog_ba, prog_addr, prog_data, prog_dsn} = '0;
        tick_no = 0;
        wd_cycles = 0;
        n_rows = 0;
        void'($urandom(53));
        build_table();

        repeat (8) begin
            tick();
            check_val("reset sdram_init", 32'd1, 32'(sdram_init));
            check_val("reset game_rst_n", 32'd0, 32'(game_rst_n));
        end
        rst_n = 1'b1;
        check_count("reset release");

        rst_req = 1'b1;
        tick();
        check_val("rst_req game_rst_n", 32'd0, 32'(game_rst_n));
        rst_req = 1'b0;
        check_count("rst_req restart");

        pll_locked = 1'b0;
        tick();
        check_val("pll_locked game_rst_n", 32'd0, 32'(game_rst_n));
        pll_locked = 1'b1;
        check_count("pll_locked restart");

        // Bank 3 read waits through the whole download
        downloading = 1'b1;
        start_rows(5, 5);
        run_entries(0, 4);
        downloading = 1'b0;
        finish_rows(5, 5);
        tick();
        run_entries(6, N_ROWS - 1);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clock.sv
// Testbench clock source
// Free-running clock with a 100 ns period, low at time zero
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk
);

    localparam realtime HALF_PERIOD = 50.0;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: board_top.sv
// Board memory-access top level
// Ties the reset sequencer, the bank arbiter and the pipelined memory
// together. The per-bank game ports are gathered into arrays here.
`timescale 1ns/10ps
`default_nettype none

`include "board_cfg.svh"

module board_top (
    input  wire                       clk_rom,
    input  wire                       rst_n,
    input  wire                       pll_locked,
    input  wire                       rst_req,
    input  wire                       downloading,
    input  wire board_pkg::addr_t     ba0_addr,
    input  wire board_pkg::addr_t     ba1_addr,
    input  wire board_pkg::addr_t     ba2_addr,
    input  wire board_pkg::addr_t     ba3_addr,
    input  wire board_pkg::data_t     ba0_din,
    input  wire board_pkg::data_t     ba1_din,
    input  wire board_pkg::data_t     ba2_din,
    input  wire board_pkg::data_t     ba3_din,
    input  wire board_pkg::dsn_t      ba0_dsn,
    input  wire board_pkg::dsn_t      ba1_dsn,
    input  wire board_pkg::dsn_t      ba2_dsn,
    input  wire board_pkg::dsn_t      ba3_dsn,
    input  wire board_pkg::bank_vec_t ba_rd,
    input  wire board_pkg::bank_vec_t ba_wr,
    input  wire                       prog_rd,
    input  wire                       prog_we,
    input  wire board_pkg::bank_t     prog_ba,
    input  wire board_pkg::addr_t     prog_addr,
    input  wire board_pkg::data_t     prog_data,
    input  wire board_pkg::dsn_t      prog_dsn,
    output board_pkg::bank_vec_t      ba_ack,
    output board_pkg::bank_vec_t      ba_rdy,
    output logic                      prog_ack,
    output logic                      prog_rdy,
    output board_pkg::data_t          sdram_dout,
    output logic                      sdram_init,
    output logic                      game_rst_n
);

    import board_pkg::*;

    addr_t    ba_addr [`BOARD_BANKS];
    data_t    ba_din  [`BOARD_BANKS];
    dsn_t     ba_dsn  [`BOARD_BANKS];
    logic     req_valid, rsp_valid;
    mem_req_t mem_req;
    src_t     req_src, rsp_src;
    mem_rsp_t mem_rsp;

    assign ba_addr = '{ba0_addr, ba1_addr, ba2_addr, ba3_addr};
    assign ba_din  = '{ba0_din, ba1_din, ba2_din, ba3_din};
    assign ba_dsn  = '{ba0_dsn, ba1_dsn, ba2_dsn, ba3_dsn};

    // Valid while rdy is high
    assign sdram_dout = mem_rsp.data;

    board_reset u_reset (
        .clk_rom     ( clk_rom     ),
        .rst_n       ( rst_n       ),
        .pll_locked  ( pll_locked  ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .sdram_init  ( sdram_init  ),
        .game_rst_n  ( game_rst_n  )
    );

    bank_arbiter u_arbiter (
        .clk_rom     ( clk_rom     ),
        .rst_n       ( rst_n       ),
        .sdram_init  ( sdram_init  ),
        .downloading ( downloading ),
        .ba_rd       ( ba_rd       ),
        .ba_wr       ( ba_wr       ),
        .ba_addr     ( ba_addr     ),
        .ba_din      ( ba_din      ),
        .ba_dsn      ( ba_dsn      ),
        .prog_rd     ( prog_rd     ),
        .prog_we     ( prog_we     ),
        .prog_ba     ( prog_ba     ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_dsn    ( prog_dsn    ),
        .rsp_valid   ( rsp_valid   ),
        .rsp_src     ( rsp_src     ),
        .ba_ack      ( ba_ack      ),
        .ba_rdy      ( ba_rdy      ),
        .prog_ack    ( prog_ack    ),
        .prog_rdy    ( prog_rdy    ),
        .req_valid   ( req_valid   ),
        .req         ( mem_req     ),
        .req_src     ( req_src     )
    );

    rom_memory u_memory (
        .clk_rom     ( clk_rom     ),
        .rst_n       ( rst_n       ),
        .req_valid   ( req_valid   ),
        .req         ( mem_req     ),
        .req_src     ( req_src     ),
        .rsp_valid   ( rsp_valid   ),
        .rsp_src     ( rsp_src     ),
        .rsp         ( mem_rsp     )
    );

endmodule

`default_nettype wire

// File: rom_memory.sv
// Pipelined on-chip memory
// Four banks of words with active-low byte write masks. Each accepted
// request returns its tag and data a fixed number of cycles later, so
// several requests may be in flight at once.
`timescale 1ns/10ps
`default_nettype none

`include "board_cfg.svh"

module rom_memory (
    input  wire                      clk_rom,
    input  wire                      rst_n,
    input  wire                      req_valid,
    input  wire board_pkg::mem_req_t req,
    input  wire board_pkg::src_t     req_src,
    output logic                     rsp_valid,
    output board_pkg::src_t          rsp_src,
    output board_pkg::mem_rsp_t      rsp
);

    import board_pkg::*;

    localparam int DEPTH = `BOARD_BANKS << `BOARD_AW;
    localparam int HB    = `BOARD_DW / 2;
    localparam int LAT   = `BOARD_MEM_LAT;

    data_t              mem [DEPTH];
    logic [`BOARD_AW+1:0] idx;
    data_t              cur_word;
    data_t              new_word;

    logic [LAT-1:0]     vld_pipe;
    src_t               src_pipe  [LAT];
    data_t              data_pipe [LAT];

    assign idx      = {req.ba, req.addr};
    assign cur_word = mem[idx];

    // Byte merge, a low mask bit lets that byte through
    assign new_word[HB-1:0]         = req.dsn[0] ? cur_word[HB-1:0] : req.data[HB-1:0];
    assign new_word[`BOARD_DW-1:HB] = req.dsn[1] ? cur_word[`BOARD_DW-1:HB]
                                                 : req.data[`BOARD_DW-1:HB];

    always_ff @(posedge clk_rom) begin
        if (req_valid && req.wr) mem[idx] <= new_word;
    end

    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= req_valid;
            for (int k = 1; k < LAT; k++) vld_pipe[k] <= vld_pipe[k-1];
        end
    end

    // Read data as seen after this cycle's write
    always_ff @(posedge clk_rom) begin
        src_pipe[0]  <= req_src;
        data_pipe[0] <= req.wr ? new_word : cur_word;
        for (int k = 1; k < LAT; k++) begin
            src_pipe[k]  <= src_pipe[k-1];
            data_pipe[k] <= data_pipe[k-1];
        end
    end

    assign rsp_valid = vld_pipe[LAT-1];
    assign rsp_src   = src_pipe[LAT-1];
    assign rsp       = '{src: src_pipe[LAT-1], data: data_pipe[LAT-1]};

endmodule

`default_nettype wire

// File: bank_arbiter.sv
// Shared memory arbiter
// Grants one requester per cycle among four game banks and the ROM
// download port. Downloads own the memory while active, otherwise the
// banks are served round robin. Response tags become rdy pulses.
`timescale 1ns/10ps
`default_nettype none

`include "board_cfg.svh"

module bank_arbiter (
    input  wire                       clk_rom,
    input  wire                       rst_n,
    input  wire                       sdram_init,
    input  wire                       downloading,
    input  wire board_pkg::bank_vec_t ba_rd,
    input  wire board_pkg::bank_vec_t ba_wr,
    input  wire board_pkg::addr_t     ba_addr [`BOARD_BANKS],
    input  wire board_pkg::data_t     ba_din  [`BOARD_BANKS],
    input  wire board_pkg::dsn_t      ba_dsn  [`BOARD_BANKS],
    input  wire                       prog_rd,
    input  wire                       prog_we,
    input  wire board_pkg::bank_t     prog_ba,
    input  wire board_pkg::addr_t     prog_addr,
    input  wire board_pkg::data_t     prog_data,
    input  wire board_pkg::dsn_t      prog_dsn,
    input  wire                       rsp_valid,
    input  wire board_pkg::src_t      rsp_src,
    output board_pkg::bank_vec_t      ba_ack,
    output board_pkg::bank_vec_t      ba_rdy,
    output logic                      prog_ack,
    output logic                      prog_rdy,
    output logic                      req_valid,
    output board_pkg::mem_req_t       req,
    output board_pkg::src_t           req_src
);

    import board_pkg::*;

    arb_state_e state, state_next;
    bank_t      rr_last;
    bank_t      pick;
    logic       pick_ok;
    bank_vec_t  busy;
    bank_vec_t  bank_req;
    logic       prog_busy;
    logic       grant_prog, grant_bank;
    mem_req_t   next_req;
    src_t       next_src;

    always_comb begin
        state_next = state;
        case (state)
            ARB_SCAN:     if (downloading) state_next = ARB_DOWNLOAD;
            ARB_DOWNLOAD: if (!downloading && !prog_busy) state_next = ARB_SCAN;
            default:      state_next = ARB_SCAN;
        endcase
    end

    // Banks already in flight must not be accepted twice
    assign bank_req = (ba_rd | ba_wr) & ~busy;

    // Round robin scan, starting after the last granted bank
    always_comb begin
        bank_t idx;
        pick_ok = 1'b0;
        pick    = rr_last;
        for (int k = 1; k <= `BOARD_BANKS; k++) begin
            idx = rr_last + bank_t'(k);
            if (!pick_ok && bank_req[idx]) begin
                pick_ok = 1'b1;
                pick    = idx;
            end
        end
    end

    assign grant_prog = !sdram_init && state == ARB_DOWNLOAD &&
                        (prog_rd || prog_we) && !prog_busy;
    assign grant_bank = !sdram_init && state == ARB_SCAN && !downloading && pick_ok;

    always_comb begin
        if (grant_prog) begin
            next_req = '{wr: prog_we, ba: prog_ba, addr: prog_addr,
                         data: prog_data, dsn: prog_dsn};
            next_src = '{prog: 1'b1, ba: prog_ba};
        end else begin
            next_req = '{wr: ba_wr[pick], ba: pick, addr: ba_addr[pick],
                         data: ba_din[pick], dsn: ba_dsn[pick]};
            next_src = '{prog: 1'b0, ba: pick};
        end
    end

    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            state     <= ARB_SCAN;
            rr_last   <= '0;
            busy      <= '0;
            prog_busy <= 1'b0;
            ba_ack    <= '0;
            prog_ack  <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            state     <= state_next;
            ba_ack    <= '0;
            prog_ack  <= 1'b0;
            req_valid <= grant_prog || grant_bank;
            busy      <= (busy & ~ba_rdy) | (grant_bank ? bank_vec_t'(1) << pick : '0);
            if (prog_rdy) prog_busy <= 1'b0;
            if (grant_prog) begin
                prog_ack  <= 1'b1;
                prog_busy <= 1'b1;
            end else if (grant_bank) begin
                ba_ack[pick] <= 1'b1;
                rr_last      <= pick;
            end
        end
    end

    always_ff @(posedge clk_rom) begin
        req     <= next_req;
        req_src <= next_src;
    end

    // Returning tag selects the rdy line
    always_comb begin
        ba_rdy   = '0;
        prog_rdy = rsp_valid && rsp_src.prog;
        if (rsp_valid && !rsp_src.prog) ba_rdy[rsp_src.ba] = 1'b1;
    end

endmodule

`default_nettype wire

// File: board_reset.sv
// Board reset sequencer
// Counts clean cycles after reset with the PLL locked and no reset
// request. The count opens the memory-init window first and then
// releases the game reset. A running ROM download keeps the game in reset.
`timescale 1ns/10ps
`default_nettype none

`include "board_cfg.svh"

module board_reset (
    input  wire  clk_rom,
    input  wire  rst_n,
    input  wire  pll_locked,
    input  wire  rst_req,
    input  wire  downloading,
    output logic sdram_init,
    output logic game_rst_n
);

    localparam int CNT_W = $clog2(`BOARD_RST_CYCLES + 1);

    logic [CNT_W-1:0] cnt;
    logic             cnt_done;
    logic             init_done;

    // Any broken condition restarts the whole sequence
    always_ff @(posedge clk_rom) begin
        if (!rst_n || !pll_locked || rst_req) begin
            cnt <= '0;
        end else if (!cnt_done) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign cnt_done  = (cnt == CNT_W'(`BOARD_RST_CYCLES));
    assign init_done = (cnt >= CNT_W'(`BOARD_INIT_CYCLES));

    assign sdram_init = !init_done;

    // Game stays held while the ROM is being loaded
    assign game_rst_n = cnt_done && !downloading;

endmodule

`default_nettype wire

// File: board_pkg.sv
// Board package
// Shared types for the memory-access core: address and data words,
// byte masks, bank indexes, the arbiter to memory request and response
// structs and the arbiter state encoding
`default_nettype none

`include "board_cfg.svh"

package board_pkg;

    typedef logic [`BOARD_AW-1:0]    addr_t;
    typedef logic [`BOARD_DW-1:0]    data_t;
    // Active low, bit 0 is the low byte
    typedef logic [1:0]              dsn_t;
    typedef logic [1:0]              bank_t;
    typedef logic [`BOARD_BANKS-1:0] bank_vec_t;

    // Who issued a memory request
    typedef struct packed {
        logic  prog;
        bank_t ba;
    } src_t;

    typedef struct packed {
        logic  wr;
        bank_t ba;
        addr_t addr;
        data_t data;
        dsn_t  dsn;
    } mem_req_t;

    typedef struct packed {
        src_t  src;
        data_t data;
    } mem_rsp_t;

    typedef enum logic {
        ARB_SCAN,
        ARB_DOWNLOAD
    } arb_state_e;

endpackage

`default_nettype wire

// File: board_cfg.svh
// Board configuration constants
// Widths, bank count, reset and memory-init lengths, and the memory
// pipeline latency shared by the memory-access core
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// Word address width inside one bank
`define BOARD_AW 10

// Data bus width, two bytes
`define BOARD_DW 16

// Number of game banks sharing the memory
`define BOARD_BANKS 4

// Game reset length after the system leaves reset
`define BOARD_RST_CYCLES 16

// Memory-init window, must not exceed BOARD_RST_CYCLES
`define BOARD_INIT_CYCLES 8

// Cycles from ack to rdy
`define BOARD_MEM_LAT 2

`endif
